// File: singleCpuPkg.sv
package singleCpuPkg;

    localparam int xlen      = 32;
    localparam int imemDepth = 32;               // ROM words
    localparam int dmemDepth = 64;               // RAM words
    localparam int imemAw    = $clog2(imemDepth);
    localparam int dmemAw    = $clog2(dmemDepth);

    // Major opcodes
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opI      = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    // funct3 codes
    localparam logic [2:0] f3AddSub = 3'b000;    // add, sub, addi
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010;    // lw, sw
    localparam logic [2:0] f3Beq    = 3'b000;

    typedef logic [xlen-1:0] wordT;

    typedef enum logic [2:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt
    } aluOpT;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iFmtT;

    // Store offset split around rs2/rs1
    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sFmtT;

    // Branch offset, bit 0 implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bFmtT;

    typedef union packed {
        rFmtT r;
        iFmtT i;
        sFmtT s;
        bFmtT b;
    } instT;

endpackage

// File: ctrlIf.sv
`timescale 1ns/1ps

interface ctrlIf;
    import singleCpuPkg::*;

    logic  regWrite;
    logic  aluSrc;   // High selects the immediate
    logic  memWrite;
    logic  memToReg; // Load data to rd
    logic  branch;
    aluOpT aluOp;
    wordT  imm;      // Sign extended, B offset pre-shifted

    modport dec (
        output regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );

    modport exe (
        input regWrite, aluSrc, memWrite, memToReg, branch, aluOp, imm
    );

endinterface

// File: pcUnit.sv
`timescale 1ns/1ps

module pcUnit (
    input  logic               CLK,
    input  logic               rstN,
    input  logic               takeBranch,
    input  singleCpuPkg::wordT imm,
    output singleCpuPkg::wordT pc
);
    import singleCpuPkg::*;

    wordT pcPlus4;
    wordT branchTarget;
    wordT nextPc;

    assign pcPlus4      = pc + wordT'(4);                   // Sequential fetch
    assign branchTarget = pc + imm;                         // imm already shifted
    assign nextPc       = takeBranch ? branchTarget : pcPlus4;

    // Restart from address 0
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

// File: instMem.sv
`timescale 1ns/1ps

module instMem (
    input  singleCpuPkg::wordT pc,
    output singleCpuPkg::instT inst
);
    import singleCpuPkg::*;

    wordT rom [imemDepth] = '{default: '0};  // Unloaded words decode as no-op
    wordT wordIdx;

    initial begin
        $readmemh("program.hex", rom);
    end

    assign wordIdx = pc >> 2;                // Byte to word address

    // Zero past the end of the ROM
    assign inst = (wordIdx < imemDepth) ? instT'(rom[wordIdx[imemAw-1:0]]) : instT'('0);

endmodule

// File: decoder.sv
`timescale 1ns/1ps

module decoder (
    input logic               rstN,
    input singleCpuPkg::instT inst,
    ctrlIf.dec                ctrl
);
    import singleCpuPkg::*;

    wordT  immI;
    wordT  immS;
    wordT  immB;
    aluOpT fnOp;     // Op from funct fields
    logic  fnLegal;  // funct3 known for this opcode
    logic  isR;

    assign isR = (inst.r.opcode == opR);

    // Sign extension of the three immediate views
    assign immI = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign immS = {{20{inst.s.immHi[6]}}, inst.s.immHi, inst.s.immLo};
    assign immB = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                   inst.b.imm10to5, inst.b.imm4to1, 1'b0};  // Shift by one folded in

    // ALU control
    always_comb begin
        fnOp    = aluAdd;
        fnLegal = 1'b1;
        case (inst.r.funct3)
            f3AddSub: fnOp = (isR && inst.r.funct7[5]) ? aluSub : aluAdd;
            f3Slt: begin
                fnOp    = aluSlt;
                fnLegal = isR;  // No slti
            end
            f3Or:     fnOp = aluOr;
            f3And:    fnOp = aluAnd;
            default:  fnLegal = 1'b0;
        endcase
    end

    // Main control
    always_comb begin
        ctrl.regWrite = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.aluOp    = aluAdd;
        ctrl.imm      = immI;
        case (inst.r.opcode)
            opR: begin
                ctrl.regWrite = fnLegal;
                ctrl.aluOp    = fnOp;
            end
            opI: begin
                ctrl.regWrite = fnLegal;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = fnOp;
            end
            opLoad: begin
                ctrl.regWrite = (inst.i.funct3 == f3Word);  // Word loads only
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
            end
            opStore: begin
                ctrl.memWrite = (inst.s.funct3 == f3Word);
                ctrl.aluSrc   = 1'b1;
                ctrl.imm      = immS;
            end
            opBranch: begin
                ctrl.branch = (inst.b.funct3 == f3Beq);
                ctrl.aluOp  = aluSub;  // Equal when difference is zero
                ctrl.imm    = immB;
            end
            default: ;                 // Retires as no-op
        endcase
        if (!rstN) begin               // Quiet during reset
            ctrl.regWrite = 1'b0;
            ctrl.memWrite = 1'b0;
            ctrl.branch   = 1'b0;
        end
    end

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic               CLK,
    input  logic               we,
    input  logic [4:0]         rs1,
    input  logic [4:0]         rs2,
    input  logic [4:0]         rd,
    input  singleCpuPkg::wordT wd,
    output singleCpuPkg::wordT rd1,
    output singleCpuPkg::wordT rd2
);
    import singleCpuPkg::*;

    wordT regs [32] = '{default: '0};  // Power-up contents zero

    // Write-back at end of cycle
    always_ff @(posedge CLK) begin
        if (we && (rd != 5'd0)) begin
            regs[rd] <= wd;  // x0 writes dropped
        end
    end

    // x0 hardwired zero
    assign rd1 = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: execUnit.sv
`timescale 1ns/1ps

module execUnit (
    ctrlIf.exe                 ctrl,
    input  singleCpuPkg::wordT rd1,
    input  singleCpuPkg::wordT rd2,
    input  singleCpuPkg::wordT memRdata,
    output singleCpuPkg::wordT aluResult,
    output singleCpuPkg::wordT wbData,
    output logic               takeBranch
);
    import singleCpuPkg::*;

    wordT opB;
    logic zero;

    assign opB = ctrl.aluSrc ? ctrl.imm : rd2;  // Operand mux

    always_comb begin
        case (ctrl.aluOp)
            aluAdd:  aluResult = rd1 + opB;
            aluSub:  aluResult = rd1 - opB;
            aluAnd:  aluResult = rd1 & opB;
            aluOr:   aluResult = rd1 | opB;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, $signed(rd1) < $signed(opB)};
            default: aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // beq taken when operands match
    assign takeBranch = ctrl.branch && zero;

    assign wbData = ctrl.memToReg ? memRdata : aluResult;  // Write-back mux

endmodule

// File: dataMem.sv
`timescale 1ns/1ps

module dataMem (
    input  logic               CLK,
    input  logic               we,
    input  singleCpuPkg::wordT addr,
    input  singleCpuPkg::wordT wdata,
    output singleCpuPkg::wordT rdata
);
    import singleCpuPkg::*;

    wordT               mem [dmemDepth] = '{default: '0};
    logic [dmemAw-1:0]  wordIdx;

    assign wordIdx = addr[dmemAw+1:2];  // Word index, byte offset ignored

    // Store commits on the edge
    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

    assign rdata = mem[wordIdx];        // Async read

endmodule

// File: singleCpu.sv
`timescale 1ns/1ps

module singleCpu (
    input  logic               CLK,
    input  logic               rstN,
    output singleCpuPkg::wordT pc,
    output singleCpuPkg::instT OUT,       // Current instruction
    output logic               wbEn,
    output logic [4:0]         wbAddr,
    output singleCpuPkg::wordT wbData,
    output logic               memWe,
    output singleCpuPkg::wordT memAddr,   // ALU result
    output singleCpuPkg::wordT memWdata   // rs2 data
);
    import singleCpuPkg::*;

    wordT rd1;
    wordT memRdata;
    logic takeBranch;

    ctrlIf ctrl ();

    // Trace taps
    assign wbEn   = ctrl.regWrite;
    assign wbAddr = OUT.r.rd;
    assign memWe  = ctrl.memWrite;

    pcUnit i_pcUnit (
        .CLK        (CLK),
        .rstN       (rstN),
        .takeBranch (takeBranch),
        .imm        (ctrl.imm),
        .pc         (pc)
    );

    instMem i_instMem (
        .pc   (pc),
        .inst (OUT)
    );

    decoder i_decoder (
        .rstN (rstN),
        .inst (OUT),
        .ctrl (ctrl.dec)
    );

    regFile i_regFile (
        .CLK (CLK),
        .we  (ctrl.regWrite),
        .rs1 (OUT.r.rs1),
        .rs2 (OUT.r.rs2),
        .rd  (OUT.r.rd),
        .wd  (wbData),
        .rd1 (rd1),
        .rd2 (memWdata)
    );

    execUnit i_execUnit (
        .ctrl       (ctrl.exe),
        .rd1        (rd1),
        .rd2        (memWdata),
        .memRdata   (memRdata),
        .aluResult  (memAddr),
        .wbData     (wbData),
        .takeBranch (takeBranch)
    );

    dataMem i_dataMem (
        .CLK   (CLK),
        .we    (ctrl.memWrite),
        .addr  (memAddr),
        .wdata (memWdata),
        .rdata (memRdata)
    );

endmodule

// File: singleCpuTb.sv
`timescale 1ns/1ps

module singleCpuTb;
    import singleCpuPkg::*;

    localparam int progLen     = 25;                       // Words in program.hex
    localparam int resetCycles = 5;
    localparam int cycleLimit  = 4 * progLen + resetCycles;

    logic       CLK;
    logic       rstN;
    wordT       pc;
    instT       curInst;
    logic       wbEn;
    logic [4:0] wbAddr;
    wordT       wbData;
    logic       memWe;
    wordT       memAddr;
    wordT       memWdata;

    // Mirror state of the golden model
    wordT romModel [imemDepth];
    wordT regModel [32];
    wordT memModel [dmemDepth];
    wordT pcModel;

    int errCount   = 0;
    int testCount  = 0;
    int failCount  = 0;
    int cycleCount = 0;
    int skipWrites = 0;   // Writes to x15, only a skipped addi targets it

    singleCpu i_singleCpu (
        .CLK      (CLK),
        .rstN     (rstN),
        .pc       (pc),
        .OUT      (curInst),
        .wbEn     (wbEn),
        .wbAddr   (wbAddr),
        .wbData   (wbData),
        .memWe    (memWe),
        .memAddr  (memAddr),
        .memWdata (memWdata)
    );

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;   // 20 ns period
    end

    // Abort if the CPU never gets through the program
    initial begin
        while (cycleCount < cycleLimit) begin
            @(posedge CLK);
            cycleCount++;
        end
        $display("Timeout: run stopped after %0d cycles without finishing the tests", cycleCount);
        $display("Done: errors found");
        $finish;
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic checkInst(input string name, input instT got, input instT exp);
        if (got !== exp) begin
            errCount++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    // Golden model of one retired instruction, checked mid-cycle
    task automatic stepInstr();
        instT ins;
        wordT a;
        wordT b;
        wordT immI;
        wordT immS;
        wordT immB;
        wordT res;
        wordT addr;
        wordT nextPc;
        logic expWe;
        logic expMemWe;
        @(negedge CLK);                                   // Outputs settled here
        ins    = ((pcModel >> 2) < imemDepth) ? instT'(romModel[pcModel >> 2]) : instT'('0);
        a      = regModel[ins.r.rs1];
        b      = regModel[ins.r.rs2];
        immI   = $signed(ins.i.imm);
        immS   = $signed({ins.s.immHi, ins.s.immLo});
        immB   = $signed({ins.b.imm12, ins.b.imm11, ins.b.imm10to5, ins.b.imm4to1, 1'b0});
        res    = '0;
        addr   = a + immI;                                // Load address
        nextPc = pcModel + 32'd4;
        expWe    = 1'b0;
        expMemWe = 1'b0;
        case (ins.r.opcode)
            opR: begin
                expWe = 1'b1;
                case (ins.r.funct3)
                    3'b000:  res = ins.r.funct7[5] ? a - b : a + b;
                    3'b010:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            opI: begin
                expWe = 1'b1;
                case (ins.i.funct3)
                    3'b110:  res = a | immI;
                    3'b111:  res = a & immI;
                    default: res = a + immI;
                endcase
            end
            opLoad: begin
                expWe = 1'b1;
                res   = memModel[addr[7:2]];
            end
            opStore: begin
                expMemWe = 1'b1;
                addr     = a + immS;
            end
            opBranch: begin
                if (a == b) begin
                    nextPc = pcModel + immB;              // beq taken
                end
            end
            default: ;                                    // No-op
        endcase
        checkWord("pc", pc, pcModel);
        checkInst("OUT", curInst, ins);
        checkBit("wbEn", wbEn, expWe);
        checkBit("memWe", memWe, expMemWe);
        if (expWe) begin
            checkWord("wbAddr", wordT'(wbAddr), wordT'(ins.r.rd));
            checkWord("wbData", wbData, res);
        end
        if (expMemWe) begin
            checkWord("memAddr", memAddr, addr);
            checkWord("memWdata", memWdata, b);
        end
        if (wbEn === 1'b1 && wbAddr == 5'd15) begin
            skipWrites++;
        end
        // Commit like the clock edge will
        if (expWe && ins.r.rd != 5'd0) begin
            regModel[ins.r.rd] = res;
        end
        if (expMemWe) begin
            memModel[addr[7:2]] = b;
        end
        pcModel = nextPc;
    endtask

    task automatic reportTest(input string name, input int errBefore);
        testCount++;
        if (errCount == errBefore) begin
            $display("PASS  %s", name);
        end else begin
            failCount++;
            $display("FAIL  %s: %0d mismatches", name, errCount - errBefore);
        end
    endtask

    // Quiet outputs while held, release on the last reset edge
    task automatic resetTest();
        int errBefore;
        errBefore = errCount;
        for (int i = 1; i <= resetCycles; i++) begin
            @(posedge CLK);
            if (i == resetCycles) begin
                rstN <= 1'b1;
            end else begin
                @(negedge CLK);
                checkWord("pc", pc, '0);
                checkBit("wbEn", wbEn, 1'b0);
                checkBit("memWe", memWe, 1'b0);
                checkInst("OUT", curInst, instT'(romModel[0]));
            end
        end
        reportTest("reset", errBefore);
    endtask

    // First step also checks pc 0 and ROM word 0 after release
    task automatic arithTest();
        int errBefore;
        errBefore = errCount;
        repeat (9) stepInstr();                           // 3 addi, 6 R-type
        reportTest("register arithmetic", errBefore);
    endtask

    task automatic immLogicTest();
        int errBefore;
        errBefore = errCount;
        repeat (4) stepInstr();                           // andi, ori, x0 write, x0 read
        reportTest("immediate logic and x0", errBefore);
    endtask

    task automatic memoryTest();
        int errBefore;
        errBefore = errCount;
        repeat (3) stepInstr();                           // sw, lw back, lw unwritten
        reportTest("store and load", errBefore);
    endtask

    task automatic branchTest();
        int errBefore;
        errBefore = errCount;
        repeat (17) stepInstr();                          // Loop runs 3 times, then 2 no-ops
        if (skipWrites != 0) begin
            errCount++;
            $display("A skipped instruction wrote x15 %0d times", skipWrites);
        end
        reportTest("branches", errBefore);
    endtask

    initial begin
        rstN     = 1'b0;
        pcModel  = '0;
        romModel = '{default: '0};
        regModel = '{default: '0};
        memModel = '{default: '0};
        $readmemh("program.hex", romModel);
        resetTest();
        arithTest();
        immLogicTest();
        memoryTest();
        branchTest();
        $display("Tests run: %0d, failed: %0d, mismatches: %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: program.hex
// One 32-bit instruction word per line, word address 0 first
00500093 // addi section: addi x1, x0, 5
FFD00113 // addi x2, x0, -3
00C00193 // addi x3, x0, 12
00208233 // R-type section: add x4, x1, x2
402082B3 // sub x5, x1, x2
0030F333 // and x6, x1, x3
0030E3B3 // or x7, x1, x3
00112433 // slt x8, x2, x1
0020A4B3 // slt x9, x1, x2
0F017513 // immediate logic section: andi x10, x2, 0xf0
FF00E593 // ori x11, x1, -16
00708013 // addi x0, x1, 7
00100633 // add x12, x0, x1
00B02423 // memory section: sw x11, 8(x0)
00802683 // lw x13, 8(x0)
01002703 // lw x14, 16(x0)
00C08463 // branch section: beq x1, x12, +8
06300793 // addi x15, x0, 99
00208463 // beq x1, x2, +8
00300813 // addi x16, x0, 3
00188893 // loop: addi x17, x17, 1
FFF80813 // addi x16, x16, -1
00080463 // beq x16, x0, +8
FE000AE3 // beq x0, x0, -12
01102623 // sw x17, 12(x0)

// File: singleCpu.f
singleCpuPkg.sv
ctrlIf.sv
pcUnit.sv
instMem.sv
decoder.sv
regFile.sv
execUnit.sv
dataMem.sv
singleCpu.sv
singleCpuTb.sv

// File: Bender.yml
package:
  name: singleCpu

sources:
  - singleCpuPkg.sv
  - ctrlIf.sv
  - pcUnit.sv
  - instMem.sv
  - decoder.sv
  - regFile.sv
  - execUnit.sv
  - dataMem.sv
  - singleCpu.sv
  - target: test
    files:
      - singleCpuTb.sv
